// File: source/cart_cfg_defs.svh
`ifndef CART_CFG_DEFS_SVH
`define CART_CFG_DEFS_SVH

// ====================
// register window
// ====================

`define CFG_BASE_BIT 16                 // address bit that selects the window.

// unlock sequence written in order to a key register.
`define CFG_KEY_0 16'h5F55
`define CFG_KEY_1 16'h4E4C
`define CFG_KEY_2 16'h4F43
`define CFG_KEY_3 16'h4B5F

`define CFG_LOCK_WORD 16'hFFFF          // written twice to lock again.

`define CFG_IDENTIFIER 32'h4341_5254

// ====================
// command engine
// ====================

`define CFG_CMD_GET 8'h63               // ascii c.
`define CFG_CMD_SET 8'h43               // ascii C.

`define CFG_STORE_DEPTH 8

`endif

// File: source/cart_cfg_pkg.sv
`default_nettype none

package cart_cfg_pkg;

    // register map with one 16-bit word per index.
    typedef enum logic [3:0] {
        REG_STATUS,
        REG_COMMAND,
        REG_DATA_0_H,
        REG_DATA_0_L,
        REG_DATA_1_H,
        REG_DATA_1_L,
        REG_IDENTIFIER_H,
        REG_IDENTIFIER_L,
        REG_KEY_H,
        REG_KEY_L
    } reg_index_t;

    typedef struct packed {
        logic        hit;               // address falls in the window.
        logic        write;
        logic        read;
        reg_index_t  index;
        logic [15:0] wdata;
    } cfg_req_t;

    typedef struct packed {
        logic        pending;
        logic [7:0]  cmd;
        logic [31:0] arg0;
        logic [31:0] arg1;
    } cfg_cmd_t;

    typedef struct packed {
        logic        done;              // one cycle.
        logic        error;             // valid with done.
        logic        irq;
        logic [31:0] result0;
        logic [31:0] result1;
    } cfg_rsp_t;

endpackage

`default_nettype wire

// File: source/cart_bus_decode.sv
`default_nettype none

`include "cart_cfg_defs.svh"

module cart_bus_decode (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic [16:0]           bus_address,
    input  wire logic [15:0]           bus_wdata,
    input  wire logic                  bus_write,
    input  wire logic                  bus_read,
    output cart_cfg_pkg::cfg_req_t     req
);

    logic                     hit;
    logic                     hit_q;
    logic                     write_q;
    logic                     read_q;
    cart_cfg_pkg::reg_index_t index_q;
    logic [15:0]              wdata_q;

    // window sits at the base bit with a 32-byte span below it.
    assign hit = bus_address[`CFG_BASE_BIT] && (bus_address[15:5] == 11'd0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hit_q   <= 1'b0;
            write_q <= 1'b0;
            read_q  <= 1'b0;
        end else begin
            hit_q   <= hit;
            write_q <= bus_write;
            read_q  <= bus_read;
        end
    end

    // register index and write data follow the bus every cycle.
    always_ff @(posedge clk) begin
        index_q <= cart_cfg_pkg::reg_index_t'(bus_address[4:1]);
        wdata_q <= bus_wdata;
    end

    assign req = '{
        hit:   hit_q,
        write: write_q,
        read:  read_q,
        index: index_q,
        wdata: wdata_q
    };

endmodule

`default_nettype wire

// File: source/cart_cfg_regs.sv
`default_nettype none

`include "cart_cfg_defs.svh"

module cart_cfg_regs (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  console_reset,
    input  wire cart_cfg_pkg::cfg_req_t req,
    input  wire cart_cfg_pkg::cfg_rsp_t rsp,
    output cart_cfg_pkg::cfg_cmd_t     cmd,
    output logic [15:0]                rdata,
    output logic                       rstrobe,
    output logic                       irq
);

    localparam logic [31:0] IDENTIFIER = `CFG_IDENTIFIER;

    logic        wr;
    logic        unlock;
    logic        pending;
    logic [7:0]  cmd_code;
    logic [31:0] arg0;
    logic [31:0] arg1;
    logic        error;
    logic [1:0]  key_cnt;               // position in the unlock sequence.
    logic        lock_cnt;              // one lock word seen.
    logic [15:0] key_expected;

    assign wr = req.hit & req.write;

    always_comb begin
        case (key_cnt)
            2'd0:    key_expected = `CFG_KEY_0;
            2'd1:    key_expected = `CFG_KEY_1;
            2'd2:    key_expected = `CFG_KEY_2;
            default: key_expected = `CFG_KEY_3;
        endcase
    end

    // ====================
    // window state
    // ====================

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            unlock   <= 1'b0;
            pending  <= 1'b0;
            cmd_code <= 8'h00;
            arg0     <= 32'd0;
            arg1     <= 32'd0;
            error    <= 1'b0;
            irq      <= 1'b0;
            key_cnt  <= 2'd0;
            lock_cnt <= 1'b0;
        end else if (console_reset) begin
            unlock   <= 1'b0;
            pending  <= 1'b0;
            cmd_code <= 8'h00;
            arg0     <= 32'd0;
            arg1     <= 32'd0;
            error    <= 1'b0;
            irq      <= 1'b0;
            key_cnt  <= 2'd0;
            lock_cnt <= 1'b0;
        end else begin
            if (rsp.done) begin
                pending <= 1'b0;
                error   <= rsp.error;
            end

            if (wr && !unlock) begin
                // only the key registers are watched while locked.
                if (req.index == cart_cfg_pkg::REG_KEY_H ||
                    req.index == cart_cfg_pkg::REG_KEY_L) begin
                    if (req.wdata == key_expected) begin
                        key_cnt <= key_cnt + 2'd1;      // wraps to zero after the last key.
                        if (key_cnt == 2'd3) begin
                            unlock <= 1'b1;
                        end
                    end else begin
                        key_cnt <= 2'd0;
                    end
                end
            end else if (wr) begin
                case (req.index)
                    cart_cfg_pkg::REG_COMMAND: begin
                        if (!pending) begin         // busy engine drops the write.
                            pending  <= 1'b1;
                            cmd_code <= req.wdata[7:0];
                            error    <= 1'b0;
                        end
                    end
                    cart_cfg_pkg::REG_DATA_0_H: arg0[31:16] <= req.wdata;
                    cart_cfg_pkg::REG_DATA_0_L: arg0[15:0]  <= req.wdata;
                    cart_cfg_pkg::REG_DATA_1_H: arg1[31:16] <= req.wdata;
                    cart_cfg_pkg::REG_DATA_1_L: arg1[15:0]  <= req.wdata;
                    cart_cfg_pkg::REG_IDENTIFIER_H: irq <= 1'b0;
                    cart_cfg_pkg::REG_KEY_H, cart_cfg_pkg::REG_KEY_L: begin
                        if (req.wdata == `CFG_LOCK_WORD) begin
                            lock_cnt <= ~lock_cnt;
                            if (lock_cnt) begin
                                unlock <= 1'b0;
                            end
                        end else begin
                            lock_cnt <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end

            if (rsp.irq) begin
                irq <= 1'b1;    // a new request wins over a clear.
            end
        end
    end

    assign cmd = '{
        pending: pending,
        cmd:     cmd_code,
        arg0:    arg0,
        arg1:    arg1
    };

    // ====================
    // read mux
    // ====================

    always_comb begin
        case (req.index)
            cart_cfg_pkg::REG_STATUS:       rdata = {pending, error, irq, 13'd0};
            cart_cfg_pkg::REG_COMMAND:      rdata = {8'd0, cmd_code};
            cart_cfg_pkg::REG_DATA_0_H:     rdata = rsp.result0[31:16];
            cart_cfg_pkg::REG_DATA_0_L:     rdata = rsp.result0[15:0];
            cart_cfg_pkg::REG_DATA_1_H:     rdata = rsp.result1[31:16];
            cart_cfg_pkg::REG_DATA_1_L:     rdata = rsp.result1[15:0];
            cart_cfg_pkg::REG_IDENTIFIER_H: rdata = IDENTIFIER[31:16];
            cart_cfg_pkg::REG_IDENTIFIER_L: rdata = IDENTIFIER[15:0];
            default:                        rdata = 16'd0;  // keys read back zero.
        endcase
    end

    assign rstrobe = req.hit & req.read;

endmodule

`default_nettype wire

// File: source/cart_cmd_engine.sv
`default_nettype none

`include "cart_cfg_defs.svh"

module cart_cmd_engine (
    input  wire logic                  clk,
    input  wire logic                  arst_n,
    input  wire logic                  console_reset,
    input  wire cart_cfg_pkg::cfg_cmd_t cmd,
    output cart_cfg_pkg::cfg_rsp_t     rsp
);

    localparam int SEL_W = $clog2(`CFG_STORE_DEPTH);

    logic [31:0]      store [`CFG_STORE_DEPTH];
    logic [SEL_W-1:0] sel;
    logic             pending_q;
    logic             start;
    logic             busy;
    logic             done;
    logic             error;
    logic             irq_req;
    logic [31:0]      result0;
    logic [31:0]      result1;

    assign sel   = cmd.arg0[SEL_W-1:0];
    assign start = cmd.pending & ~pending_q & ~console_reset;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending_q <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            error     <= 1'b0;
            irq_req   <= 1'b0;
        end else if (console_reset) begin
            pending_q <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            error     <= 1'b0;
            irq_req   <= 1'b0;
        end else begin
            pending_q <= cmd.pending;
            busy      <= start;
            done      <= busy;
            if (start) begin
                error   <= (cmd.cmd != `CFG_CMD_GET) && (cmd.cmd != `CFG_CMD_SET);
                irq_req <= cmd.arg0[31];
            end
        end
    end

    // the store survives a console reset.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CFG_STORE_DEPTH; i++) begin
                store[i] <= 32'd0;
            end
            result0 <= 32'd0;
            result1 <= 32'd0;
        end else if (start) begin
            case (cmd.cmd)
                `CFG_CMD_GET: begin
                    result0 <= cmd.arg0;
                    result1 <= store[sel];
                end
                `CFG_CMD_SET: begin
                    result0    <= cmd.arg0;
                    result1    <= store[sel];   // old value goes back.
                    store[sel] <= cmd.arg1;
                end
                default: ;
            endcase
        end
    end

    assign rsp = '{
        done:    done,
        error:   error,
        irq:     done & irq_req,
        result0: result0,
        result1: result1
    };

endmodule

`default_nettype wire

// File: source/cart_bus_respond.sv
`default_nettype none

module cart_bus_respond (
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic [15:0] rdata,
    input  wire logic        rstrobe,
    output logic [15:0]      bus_rdata,
    output logic             bus_rvalid
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bus_rvalid <= 1'b0;
        end else begin
            bus_rvalid <= rstrobe;      // one cycle per read.
        end
    end

    // word holds until the next read.
    always_ff @(posedge clk) begin
        if (rstrobe) begin
            bus_rdata <= rdata;
        end
    end

endmodule

`default_nettype wire

// File: source/cart_cfg_top.sv
`default_nettype none

module cart_cfg_top (
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        console_reset,
    input  wire logic [16:0] bus_address,
    input  wire logic [15:0] bus_wdata,
    input  wire logic        bus_write,
    input  wire logic        bus_read,
    output logic [15:0]      bus_rdata,
    output logic             bus_rvalid,
    output logic             irq
);

    cart_cfg_pkg::cfg_req_t req;
    cart_cfg_pkg::cfg_cmd_t cmd;
    cart_cfg_pkg::cfg_rsp_t rsp;
    logic [15:0]            rdata;
    logic                   rstrobe;

    // ====================
    // input side
    // ====================

    cart_bus_decode i_cart_bus_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .bus_address (bus_address),
        .bus_wdata   (bus_wdata),
        .bus_write   (bus_write),
        .bus_read    (bus_read),
        .req         (req)
    );

    // ====================
    // window and engine
    // ====================

    cart_cfg_regs i_cart_cfg_regs (
        .clk           (clk),
        .arst_n        (arst_n),
        .console_reset (console_reset),
        .req           (req),
        .rsp           (rsp),
        .cmd           (cmd),
        .rdata         (rdata),
        .rstrobe       (rstrobe),
        .irq           (irq)
    );

    cart_cmd_engine i_cart_cmd_engine (
        .clk           (clk),
        .arst_n        (arst_n),
        .console_reset (console_reset),
        .cmd           (cmd),
        .rsp           (rsp)
    );

    // ====================
    // output side
    // ====================

    cart_bus_respond i_cart_bus_respond (
        .clk        (clk),
        .arst_n     (arst_n),
        .rdata      (rdata),
        .rstrobe    (rstrobe),
        .bus_rdata  (bus_rdata),
        .bus_rvalid (bus_rvalid)
    );

endmodule

`default_nettype wire

// File: test/cart_cfg_tb.sv
`default_nettype none

module cart_cfg_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RVALID_TIMEOUT = 8;      // cycles from a read to bus_rvalid.
    localparam int POLL_LIMIT     = 20;     // status reads before giving up.

    logic        clk;
    logic        arst_n;
    logic        console_reset;
    logic [16:0] bus_address;
    logic [15:0] bus_wdata;
    logic        bus_write;
    logic        bus_read;
    logic [15:0] bus_rdata;
    logic        bus_rvalid;
    logic        irq;
    int          checks;

    cart_cfg_top i_cart_cfg_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .console_reset (console_reset),
        .bus_address   (bus_address),
        .bus_wdata     (bus_wdata),
        .bus_write     (bus_write),
        .bus_read      (bus_read),
        .bus_rdata     (bus_rdata),
        .bus_rvalid    (bus_rvalid),
        .irq           (irq)
    );

    always #10 clk = ~clk;

    // ====================
    // bus tasks
    // ====================

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic hold_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic pulse_console_reset();
        @(posedge clk);
        console_reset <= 1'b1;
        @(posedge clk);
        console_reset <= 1'b0;
    endtask

    task automatic write_reg(input logic [16:0] addr, input logic [15:0] data);
        @(posedge clk);
        bus_address <= addr;
        bus_wdata   <= data;
        bus_write   <= 1'b1;
        @(posedge clk);
        bus_write   <= 1'b0;
    endtask

    task automatic read_reg(input logic [16:0] addr, output logic [15:0] data);
        int waited;
        @(posedge clk);
        bus_address <= addr;
        bus_read    <= 1'b1;
        @(posedge clk);
        bus_read    <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);                 // rvalid and rdata are settled here.
            waited++;
        end while (!bus_rvalid && waited < RVALID_TIMEOUT);
        if (!bus_rvalid) begin
            $display("no read data came back within %0d cycles for address %05h",
                     RVALID_TIMEOUT, addr);
            abort_run();
        end
        data = bus_rdata;
        @(negedge clk);                     // rvalid is a single-cycle pulse.
        assert (bus_rvalid === 1'b0) else begin
            $display("error at %0t ns: bus_rvalid is %b, expected %b",
                     $time, bus_rvalid, 1'b0);
            abort_run();
        end
    endtask

    task automatic check_read(input logic [16:0] addr, input logic [15:0] expected);
        logic [15:0] data;
        read_reg(addr, data);
        checks++;
        assert (data === expected) else begin
            $display("error at %0t ns: bus_rdata from %05h is %04h, expected %04h",
                     $time, addr, data, expected);
            abort_run();
        end
    endtask

    task automatic poll_idle(input logic [16:0] status_addr);
        logic [15:0] status;
        int          polls;
        polls = 0;
        do begin
            read_reg(status_addr, status);
            polls++;
        end while (status[15] && polls < POLL_LIMIT);
        if (status[15]) begin
            $display("command still pending after %0d status reads", POLL_LIMIT);
            abort_run();
        end
    endtask

    task automatic check_irq(input logic expected);
        @(negedge clk);
        checks++;
        assert (irq === expected) else begin
            $display("error at %0t ns: irq is %b, expected %b", $time, irq, expected);
            abort_run();
        end
    endtask

    // ====================
    // stimulus
    // ====================

    initial begin
        int          fd;
        int          fields;
        int          line_no;
        string       line;
        logic [7:0]  op;
        logic [16:0] addr;
        logic [15:0] data;
        logic [15:0] expected;

        clk           = 1'b0;
        arst_n        = 1'b0;
        console_reset = 1'b0;
        bus_address   = 17'd0;
        bus_wdata     = 16'd0;
        bus_write     = 1'b0;
        bus_read      = 1'b0;
        checks        = 0;
        line_no       = 0;
        hold_reset();

        fd = $fopen("test/cart_cfg_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/cart_cfg_stim.txt");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            op     = line.getc(0);
            fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h",
                             addr, data, expected);
            if (fields != 3) begin
                $display("stim line %0d does not hold three hex fields", line_no);
                abort_run();
            end
            case (op)
                "W": write_reg(addr, data);
                "R": check_read(addr, expected);
                "P": poll_idle(addr);
                "I": check_irq(expected[0]);
                "S": pulse_console_reset();
                "A": hold_reset();
                default: begin
                    $display("stim line %0d has an unknown operation", line_no);
                    abort_run();
                end
            endcase
        end
        $fclose(fd);

        if (checks == 0) begin
            $display("the stim file held no checks");
            abort_run();
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
source/cart_cfg_pkg.sv
source/cart_bus_decode.sv
source/cart_cfg_regs.sv
source/cart_cmd_engine.sv
source/cart_bus_respond.sv
source/cart_cfg_top.sv
test/cart_cfg_tb.sv

// File: Makefile
# Verilator build and run of the configuration window testbench.

TOP = cart_cfg_tb
BIN = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): vlog.f source/*.sv source/*.svh test/cart_cfg_tb.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f vlog.f

# the binary exits non-zero on $fatal, so make fails with the test.
run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

// File: test/cart_cfg_stim.txt
# columns are op, address, write data, expected value, all in hex.
# W write, R read and compare, P poll status, I compare irq, S console reset, A arst_n.
# locked window, identifier readable, command and data ignored.
R 1000C 0000 4341
R 1000E 0000 5254
W 10006 0003 0000
W 10002 0043 0000
R 10000 0000 0000
R 1000A 0000 0000
# a wrong word in the middle restarts the key sequence.
W 10012 5F55 0000
W 10012 4E4C 0000
W 10012 1234 0000
W 10012 4F43 0000
W 10012 4B5F 0000
W 10002 0043 0000
R 10000 0000 0000
# full key, then set entry 3.
W 10012 5F55 0000
W 10010 4E4C 0000
W 10012 4F43 0000
W 10010 4B5F 0000
W 10006 0003 0000
W 10008 1234 0000
W 1000A 5678 0000
W 10002 0043 0000
P 10000 0000 0000
R 10006 0000 0003
R 10008 0000 0000
R 1000A 0000 0000
R 10000 0000 0000
# get entry 3 back.
W 10002 0063 0000
P 10000 0000 0000
R 10008 0000 1234
R 1000A 0000 5678
# unknown command code.
W 10002 0055 0000
P 10000 0000 0000
R 10000 0000 4000
# set with an irq request returns the old value.
W 10004 8000 0000
W 1000A 9ABC 0000
W 10002 0043 0000
P 10000 0000 0000
R 10000 0000 2000
I 00000 0000 0001
R 1000A 0000 5678
R 10004 0000 8000
W 1000C 0000 0000
R 10000 0000 0000
I 00000 0000 0000
# lock word twice.
W 10012 FFFF 0000
W 10012 FFFF 0000
W 10002 0063 0000
R 10000 0000 0000
# unlock, raise error and irq, then console reset.
W 10012 5F55 0000
W 10012 4E4C 0000
W 10012 4F43 0000
W 10012 4B5F 0000
W 10002 0055 0000
P 10000 0000 0000
R 10000 0000 6000
I 00000 0000 0001
S 00000 0000 0000
R 10000 0000 0000
I 00000 0000 0000
W 10002 0063 0000
R 10000 0000 0000
# store kept through console reset.
W 10012 5F55 0000
W 10012 4E4C 0000
W 10012 4F43 0000
W 10012 4B5F 0000
W 10006 0003 0000
W 10002 0063 0000
P 10000 0000 0000
R 10008 0000 1234
R 1000A 0000 9ABC
# arst_n clears the store.
A 00000 0000 0000
W 10012 5F55 0000
W 10012 4E4C 0000
W 10012 4F43 0000
W 10012 4B5F 0000
W 10006 0003 0000
W 10002 0063 0000
P 10000 0000 0000
R 10006 0000 0003
R 10008 0000 0000
R 1000A 0000 0000
